// ==== sim/loopFilterTrace.txt ====
# W addr data | S,B error expectedOut (B: next sample follows at once) | N error | I cycles
# All fields hex, N is a strobe with no output expected
# Lead path only
W 0 00000400
S 40 00000000
S c0 00000000
W 0 00000403
S 40 00000004
S b5 fffffffb
W 0 00000407
S 5a 0000005a
S 83 ffffff83
W 0 0000040c
S 21 00000420
S e3 fffffc7f
W 0 0000041f
S 7f 7f000000
S 80 80ffffff
S 01 01000000
S ff ffffffff
# Integration
W 0 000004e0
S 10 00000010
B 10 00000020
B 10 00000030
S 10 00000040
W 0 000004e5
B 10 00000054
B f0 0000003c
S 08 0000004a
# Saturation
W 1 7fffff00
W 0 00000587
S 40 7fffffff
S 7f 7fffffff
S 01 7fffffff
W 1 80000100
S c0 80000000
S 80 80000000
# Hold and preload
W 1 00001000
W 0 00000ce7
S 20 00001020
S e0 00000fe0
S 05 00001005
W 1 fffff000
S 10 fffff010
S 90 ffffef90
# Enable
W 0 000004e0
S 10 fffff010
W 0 000000e0
N 40
N 40
N 7f
I 3
W 0 000004e0
S 00 fffff010
S 10 fffff020
# Back-to-back strobes
W 0 000004e7
B 01 fffff022
B 02 fffff025
B fe fffff01f
S 03 fffff027

// ==== project.f ====
hw/loopFilterPkg.sv
hw/loopControl.sv
hw/leadGain.sv
hw/loopIntegrator.sv
hw/loopFilter.sv
sim/loopFilter_assert.sv
sim/loopFilterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the loop filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile="sim.log"
simBinary="loopFilterSim"

if ! verilator --binary --timing --assert -f project.f \
        --top-module loopFilterTb -o "$simBinary"; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "NO ERRORS" "$logFile"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $logFile"
    exit 1
fi

// ==== sim/loopFilterTb.sv ====
`timescale 1ns/1ps

module loopFilterTb;
    import loopFilterPkg::*;

    localparam int    halfPeriod  = 2;
    localparam int    resetCycles = 10;
    localparam string traceFile   = "sim/loopFilterTrace.txt";

    logic                         clk;
    logic                         reset;
    logic                         clkEn;
    logic signed [errorWidth-1:0] error;
    logic                         wrEn;
    cfgAddrT                      wrAddr;
    cfgWordT                      wrData;
    logic signed [accWidth-1:0]   filterOut;
    logic                         outValid;

    // One entry per operation line of the trace
    logic [7:0]  opKind[$];
    logic [31:0] opArgA[$];
    logic [31:0] opArgB[$];

    // Samples in flight and the cycle their strobe is due
    logic [31:0] expectQ[$];
    int          dueQ[$];

    int cycleCount = 0;
    int traceLines = 0;

    loopFilter i_dut (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .error     (error),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .filterOut (filterOut),
        .outValid  (outValid)
    );

    always #(halfPeriod) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at %0d ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic loadTrace();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  kind;
        logic [31:0] argA;
        logic [31:0] argB;
        fd = $fopen(traceFile, "r");
        if (fd == 0) begin
            abortRun("could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                argA = '0;
                argB = '0;
                got  = $fgets(line, fd);
                got  = $sscanf(line, "%c %h %h", kind, argA, argB);
                if (got >= 2) begin
                    case (kind)
                        "W", "S", "B", "N", "I": begin
                            opKind.push_back(kind);
                            opArgA.push_back(argA);
                            opArgB.push_back(argB);
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Config changes only once the pipeline is empty
    task automatic waitDrained();
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
        waitDrained();
        wrEn   = 1'b1;
        wrAddr = cfgAddrT'(addr[1:0]);
        wrData = data;
        @(negedge clk);
        wrEn   = 1'b0;
        wrData = '0;
    endtask

    task automatic driveSample(input logic [7:0] err, input bit hasExpect,
                               input logic [31:0] expected, input int gap);
        clkEn = 1'b1;
        error = err;
        if (hasExpect) begin
            expectQ.push_back(expected);
            dueQ.push_back(cycleCount + 2);
        end
        @(negedge clk);
        clkEn = 1'b0;
        repeat (gap) begin
            // Error input is a don't care between strobes
            error = errorWidth'($urandom);
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin : outputMonitor
        logic [31:0] expectedOut;
        int          dueCycle;
        if (!reset) begin
            if (outValid) begin
                if (expectQ.size() == 0) begin
                    abortRun("an output strobe came with no sample in flight");
                end else begin
                    expectedOut = expectQ.pop_front();
                    dueCycle    = dueQ.pop_front();
                    checkEqual(cycleCount, dueCycle, "outValid cycle");
                    checkEqual(filterOut, expectedOut, "filterOut");
                end
            end else if (dueQ.size() != 0 && dueQ[0] <= cycleCount) begin
                abortRun("the output strobe never came for a sample");
            end
        end
    end

    initial begin
        int gap;
        clk    = 1'b0;
        reset  = 1'b1;
        clkEn  = 1'b0;
        error  = '0;
        wrEn   = 1'b0;
        wrAddr = addrGains;
        wrData = '0;
        void'($urandom(91));
        loadTrace();
        traceLines = opKind.size();
        if (traceLines == 0) begin
            abortRun("the trace file holds no operations");
        end
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        foreach (opKind[i]) begin
            case (opKind[i])
                "W": writeReg(opArgA[i], opArgB[i]);
                "S": begin
                    gap = $urandom % 3;
                    driveSample(opArgA[i][7:0], 1'b1, opArgB[i], gap);
                end
                "B": driveSample(opArgA[i][7:0], 1'b1, opArgB[i], 0);
                "N": driveSample(opArgA[i][7:0], 1'b0, '0, 1);
                "I": repeat (opArgA[i]) @(negedge clk);
                default: ;
            endcase
        end
        waitDrained();
        // Give a stray strobe time to show up
        repeat (4) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

    initial begin : watchdog
        wait (traceLines > 0);
        repeat (traceLines * 10 + 50) @(posedge clk);
        abortRun("the run did not finish before the watchdog limit");
    end

endmodule

// ==== sim/loopFilter_assert.sv ====
`timescale 1ns/1ps

module loopFilter_assert (
    input logic clk,
    input logic reset,
    input logic clkEn,
    input logic loopEnable,
    input logic outValid
);

    // Strobe is cleared by the first reset edge
    resetQuiet: assert property (@(posedge clk) $past(reset) |-> !outValid)
        else $error("outValid high during reset");

    // Each strobe traces back to an enabled sample
    strobeHasSample: assert property (@(posedge clk) disable iff (reset)
        outValid |-> $past(clkEn && loopEnable, 2))
        else $error("outValid without an enabled sample two cycles earlier");

    // Each enabled sample gives a strobe two cycles on
    sampleGivesStrobe: assert property (@(posedge clk) disable iff (reset)
        $past(clkEn && loopEnable, 2) |-> outValid)
        else $error("enabled sample without outValid two cycles later");

endmodule

bind loopFilter loopFilter_assert iAssert (
    .clk        (clk),
    .reset      (reset),
    .clkEn      (clkEn),
    .loopEnable (cfg.loopEnable),
    .outValid   (outValid)
);

// ==== hw/loopFilter.sv ====
`timescale 1ns/1ps

module loopFilter (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          clkEn,
    input  logic signed [loopFilterPkg::errorWidth-1:0]   error,
    input  logic                                          wrEn,
    input  loopFilterPkg::cfgAddrT                        wrAddr,
    input  loopFilterPkg::cfgWordT                        wrData,
    output logic signed [loopFilterPkg::accWidth-1:0]     filterOut,
    output logic                                          outValid
);
    import loopFilterPkg::*;

    loopCfgT                    cfg;
    logic                       sampleEn;
    logic                       sumEn;
    logic                       preloadEn;
    logic signed [accWidth-1:0] preloadValue;
    logic signed [accWidth-1:0] leadError;
    logic signed [accWidth-1:0] lagError;

    loopControl iControl (
        .clk          (clk),
        .reset        (reset),
        .clkEn        (clkEn),
        .wrEn         (wrEn),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .cfg          (cfg),
        .sampleEn     (sampleEn),
        .sumEn        (sumEn),
        .preloadEn    (preloadEn),
        .preloadValue (preloadValue),
        .outValid     (outValid)
    );

    // Proportional path
    leadGain iLead (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (sampleEn),
        .error     (error),
        .leadExp   (cfg.leadExp),
        .leadError (leadError)
    );

    // Integral path input
    leadGain iLag (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (sampleEn),
        .error     (error),
        .leadExp   (cfg.lagExp),
        .leadError (lagError)
    );

    loopIntegrator iIntegrator (
        .clk          (clk),
        .reset        (reset),
        .sumEn        (sumEn),
        .cfg          (cfg),
        .preloadEn    (preloadEn),
        .preloadValue (preloadValue),
        .leadError    (leadError),
        .lagError     (lagError),
        .filterOut    (filterOut)
    );

endmodule

// ==== hw/loopIntegrator.sv ====
`timescale 1ns/1ps

module loopIntegrator (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        sumEn,
    input  loopFilterPkg::loopCfgT                      cfg,
    input  logic                                        preloadEn,
    input  logic signed [loopFilterPkg::accWidth-1:0]   preloadValue,
    input  logic signed [loopFilterPkg::accWidth-1:0]   leadError,
    input  logic signed [loopFilterPkg::accWidth-1:0]   lagError,
    output logic signed [loopFilterPkg::accWidth-1:0]   filterOut
);
    import loopFilterPkg::*;

    localparam logic signed [accWidth-1:0] accMax = {1'b0, {(accWidth-1){1'b1}}};
    localparam logic signed [accWidth-1:0] accMin = {1'b1, {(accWidth-1){1'b0}}};

    logic signed [accWidth-1:0] acc;
    logic signed [accWidth-1:0] accNext;
    logic signed [accWidth-1:0] outNext;

    // Add with clamp to the signed range
    function automatic logic signed [accWidth-1:0] satAdd(
        input logic signed [accWidth-1:0] a,
        input logic signed [accWidth-1:0] b
    );
        logic [accWidth:0] wide;
        wide = {a[accWidth-1], a} + {b[accWidth-1], b};
        // Overflow when the guard bit disagrees with the sign bit
        if (wide[accWidth] != wide[accWidth-1]) begin
            return wide[accWidth] ? accMin : accMax;
        end
        return wide[accWidth-1:0];
    endfunction

    assign accNext = cfg.holdIntegrator ? acc : satAdd(acc, lagError);

    // Proportional term on top of the updated integral
    assign outNext = satAdd(accNext, leadError);

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            filterOut <= '0;
        end else begin
            // Preload wins over a sample in the same cycle
            if (preloadEn) begin
                acc <= preloadValue;
            end else if (sumEn) begin
                acc <= accNext;
            end
            if (sumEn) begin
                filterOut <= outNext;
            end
        end
    end

endmodule

// ==== hw/leadGain.sv ====
`timescale 1ns/1ps

module leadGain (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          clkEn,
    input  logic signed [loopFilterPkg::errorWidth-1:0]   error,
    input  logic [loopFilterPkg::expWidth-1:0]            leadExp,
    output logic signed [loopFilterPkg::accWidth-1:0]     leadError
);
    import loopFilterPkg::*;

    // Exponent with a gain of exactly one
    localparam logic [expWidth-1:0] unityExp = expWidth'(errorWidth - 1);

    logic signed [accWidth-1:0] extError;
    logic [expWidth-1:0]        rightShift;
    logic [expWidth-1:0]        leftShift;
    logic [accWidth-1:0]        fillMask;
    logic signed [accWidth-1:0] scaled;

    assign extError   = {{(accWidth-errorWidth){error[errorWidth-1]}}, error};
    assign rightShift = unityExp - leadExp;
    assign leftShift  = leadExp - unityExp;

    // Low bits vacated by a left shift take the sign
    assign fillMask = (accWidth'(1) << leftShift) - accWidth'(1);

    always_comb begin
        if (leadExp == '0) begin
            scaled = '0;
        end else if (leadExp <= unityExp) begin
            scaled = extError >>> rightShift;
        end else if (error[errorWidth-1]) begin
            scaled = (extError <<< leftShift) | signed'(fillMask);
        end else begin
            scaled = extError <<< leftShift;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            leadError <= '0;
        end else if (clkEn) begin
            leadError <= scaled;
        end
    end

endmodule

// ==== hw/loopControl.sv ====
`timescale 1ns/1ps

module loopControl (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        clkEn,
    input  logic                                        wrEn,
    input  loopFilterPkg::cfgAddrT                      wrAddr,
    input  loopFilterPkg::cfgWordT                      wrData,
    output loopFilterPkg::loopCfgT                      cfg,
    output logic                                        sampleEn,
    output logic                                        sumEn,
    output logic                                        preloadEn,
    output logic signed [loopFilterPkg::accWidth-1:0]   preloadValue,
    output logic                                        outValid
);
    import loopFilterPkg::*;

    logic gainWrite;

    // Address decode of the write port
    assign gainWrite = wrEn && (wrAddr == addrGains);
    assign preloadEn = wrEn && (wrAddr == addrPreload);

    // Preload view of the data word goes straight to the integrator
    assign preloadValue = wrData.preload;

    // Gain register, loaded from the gains view
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (gainWrite) begin
            cfg.leadExp        <= wrData.gains.leadExp;
            cfg.lagExp         <= wrData.gains.lagExp;
            cfg.holdIntegrator <= wrData.gains.holdIntegrator;
            cfg.loopEnable     <= wrData.gains.loopEnable;
        end
    end

    // Samples are dropped while the loop is disabled
    assign sampleEn = clkEn && cfg.loopEnable;

    // Sum stage enable and output strobe follow the sample strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            sumEn    <= 1'b0;
            outValid <= 1'b0;
        end else begin
            sumEn    <= sampleEn;
            outValid <= sumEn;
        end
    end

endmodule

// ==== hw/loopFilterPkg.sv ====
package loopFilterPkg;

    // Fixed number formats of the loop filter
    localparam int errorWidth = 8;
    localparam int accWidth   = 32;
    localparam int expWidth   = 5;

    // Write port addresses outside this map are ignored
    typedef enum logic [1:0] {
        addrGains   = 2'd0,
        addrPreload = 2'd1
    } cfgAddrT;

    // Gain register layout, MSB first
    typedef struct packed {
        logic [accWidth-2*expWidth-3:0] reserved;
        logic                           holdIntegrator;
        logic                           loopEnable;
        logic [expWidth-1:0]            lagExp;
        logic [expWidth-1:0]            leadExp;
    } gainViewT;

    // Write data word, interpreted by address
    typedef union packed {
        gainViewT                   gains;
        logic signed [accWidth-1:0] preload;
    } cfgWordT;

    // Configuration seen by the datapath
    typedef struct packed {
        logic [expWidth-1:0] leadExp;
        logic [expWidth-1:0] lagExp;
        logic                holdIntegrator;
        logic                loopEnable;
    } loopCfgT;

endpackage
